/* design/lsu_pkg.sv */
package lsu_pkg;

    ////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////
    localparam int BEAT_W     = 64;
    localparam int ENTRY_W    = 128;
    localparam int LANES      = 16;
    localparam int LANE_AW    = $clog2(LANES);
    localparam int SRAM_AW    = 8;
    localparam int SRAM_DEPTH = 1 << SRAM_AW;
    // byte address inside a RAM, entry on top of lane
    localparam int SRAM_BAW   = SRAM_AW + LANE_AW;
    localparam int DRAM_AW    = 31;
    localparam int ID_W       = 8;
    localparam int LEN_W      = 8;
    localparam int ROW_W      = 4;

    typedef logic [BEAT_W-1:0]   beat_t;
    typedef logic [ENTRY_W-1:0]  entry_t;
    typedef logic [SRAM_AW-1:0]  sram_addr_t;
    typedef logic [SRAM_BAW-1:0] sram_baddr_t;
    typedef logic [LANES-1:0]    lane_mask_t;
    typedef logic [LANE_AW-1:0]  lane_idx_t;
    typedef logic [DRAM_AW-1:0]  dram_addr_t;
    typedef logic [ID_W-1:0]     axi_id_t;
    typedef logic [LEN_W-1:0]    axi_len_t;

    ////////////////////////////////////////
    // commands from the controller
    ////////////////////////////////////////

    // dram to iram/wram burst
    typedef struct packed {
        dram_addr_t       dram_addr;
        logic [LEN_W-1:0] cnt_m1;     // entries minus one, up to 127
        sram_addr_t       sram_addr;
        logic             target;     // 0 iram, 1 wram
    } load_cmd_t;

    // row feed of one RAM toward the mxu
    typedef struct packed {
        sram_addr_t       start_entry;
        lane_idx_t        start_lane;
        lane_idx_t        col_len;
        logic [ROW_W-1:0] row_len;    // rows minus one
        logic             row_dir;    // 1 ascending
    } feed_cmd_t;

endpackage

/* design/sram_if.sv */
`timescale 1ns/1ps

interface sram_if import lsu_pkg::*; ();

    // write side
    logic       wen;
    sram_addr_t waddr;
    entry_t     wdata;

    // read side, rdata one cycle after ren
    logic       ren;
    sram_addr_t raddr;
    entry_t     rdata;

    modport writer (
        output wen, waddr, wdata
    );

    modport reader (
        output ren, raddr,
        input  rdata
    );

    modport mem (
        input  wen, waddr, wdata, ren, raddr,
        output rdata
    );

endinterface

/* design/sram_bank.sv */
`timescale 1ns/1ps

module sram_bank import lsu_pkg::*; (
    input logic clk,
    sram_if.mem mem
);

    entry_t ram [SRAM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem.wen) begin
            ram[mem.waddr] <= mem.wdata;
        end
        // registered read, data holds while idle
        if (mem.ren) begin
            mem.rdata <= ram[mem.raddr];
        end
    end

    // loader and feeder never share a cycle on one address
    assert property (@(posedge clk)
        !(mem.wen && mem.ren && (mem.waddr == mem.raddr)));

endmodule

/* design/lsu_ctrl.sv */
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,

    // instruction from the decoder
    input  logic             vld,
    input  logic             ld_iram,
    input  logic             ld_wram,
    input  logic             conv,
    input  dram_addr_t       dram_addr,
    input  logic [LEN_W-1:0] len,
    input  sram_baddr_t      ld_st_addr,
    input  sram_baddr_t      iram_start_addr,
    input  lane_idx_t        iram_col_len,
    input  logic [ROW_W-1:0] iram_row_len,
    input  logic             iram_row_dir,
    input  sram_baddr_t      wram_start_addr,
    input  lane_idx_t        wram_col_len,
    input  logic [ROW_W-1:0] wram_row_len,
    input  logic             wram_row_dir,

    // completion from the workers
    input  logic             load_done,
    input  logic             iram_feed_done,
    input  logic             wram_feed_done,

    output logic             rdy,
    output logic             clr,
    output logic             load_start,
    output load_cmd_t        load_cmd,
    output logic             feed_start,
    output feed_cmd_t        iram_feed,
    output feed_cmd_t        wram_feed
);

    logic busy;
    logic loading;
    logic iram_seen;
    logic wram_seen;
    logic iram_fin;
    logic wram_fin;
    logic finish;

    assign rdy        = ~busy;
    assign load_start = vld & rdy & (ld_iram | ld_wram);
    assign feed_start = vld & rdy & conv;

    ////////////////////////////////////////
    // command build
    ////////////////////////////////////////

    // lane bits of the load address are dropped, loads are entry aligned
    assign load_cmd = '{
        dram_addr: dram_addr,
        cnt_m1:    len,
        sram_addr: ld_st_addr[SRAM_BAW-1:LANE_AW],
        target:    ld_wram
    };

    assign iram_feed = '{
        start_entry: iram_start_addr[SRAM_BAW-1:LANE_AW],
        start_lane:  iram_start_addr[LANE_AW-1:0],
        col_len:     iram_col_len,
        row_len:     iram_row_len,
        row_dir:     iram_row_dir
    };

    assign wram_feed = '{
        start_entry: wram_start_addr[SRAM_BAW-1:LANE_AW],
        start_lane:  wram_start_addr[LANE_AW-1:0],
        col_len:     wram_col_len,
        row_len:     wram_row_len,
        row_dir:     wram_row_dir
    };

    ////////////////////////////////////////
    // busy tracking
    ////////////////////////////////////////

    // feeders with different row counts finish apart
    assign iram_fin = iram_seen | iram_feed_done;
    assign wram_fin = wram_seen | wram_feed_done;
    assign finish   = loading ? load_done : (iram_fin & wram_fin);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            loading   <= 1'b0;
            iram_seen <= 1'b0;
            wram_seen <= 1'b0;
            clr       <= 1'b0;
        end else begin
            clr <= feed_start;
            if (load_start || feed_start) begin
                busy      <= 1'b1;
                loading   <= load_start;
                iram_seen <= 1'b0;
                wram_seen <= 1'b0;
            end else if (busy) begin
                iram_seen <= iram_fin;
                wram_seen <= wram_fin;
                if (finish) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // decoder must hold off while an instruction is in flight
    assert property (@(posedge clk) disable iff (!rst_n) vld |-> !busy);

endmodule

/* design/load_buffer.sv */
`timescale 1ns/1ps

module load_buffer import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_start,
    input  load_cmd_t  load_cmd,

    // axi read channels
    input  logic       arrdy,
    input  axi_id_t    rid,
    input  beat_t      rdata,
    input  logic       rlast,
    input  logic       rvld,
    output axi_id_t    arid,
    output dram_addr_t araddr,
    output axi_len_t   arlen,
    output logic       arvld,
    output logic       rrdy,

    output logic       done,
    sram_if.writer     iram_wr,
    sram_if.writer     wram_wr
);

    load_cmd_t  cmd_q;
    beat_t      low_q;
    entry_t     wdata_q;
    sram_addr_t waddr_q;
    axi_len_t   beat_cnt;
    logic       beat;
    logic       high_beat;
    logic       last_beat;
    logic       wr_q;
    logic       last_wr_q;

    // two beats per entry make the burst length odd
    assign araddr = cmd_q.dram_addr;
    assign arlen  = {cmd_q.cnt_m1[LEN_W-2:0], 1'b1};

    assign beat      = rvld & rrdy;
    assign high_beat = beat & beat_cnt[0];
    assign last_beat = beat & (beat_cnt == arlen);

    ////////////////////////////////////////
    // address phase and beat count
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arid      <= '0;
            arvld     <= 1'b0;
            rrdy      <= 1'b0;
            beat_cnt  <= '0;
            wr_q      <= 1'b0;
            last_wr_q <= 1'b0;
        end else begin
            if (load_start) begin
                arid  <= arid + 1'b1;
                arvld <= 1'b1;
            end
            if (arvld && arrdy) begin
                arvld    <= 1'b0;
                rrdy     <= 1'b1;
                beat_cnt <= '0;
            end
            if (beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (last_beat) begin
                rrdy <= 1'b0;
            end
            // entry write lands one cycle after its high beat
            wr_q      <= high_beat;
            last_wr_q <= high_beat & last_beat;
        end
    end

    ////////////////////////////////////////
    // beat packing
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (load_start) begin
            cmd_q   <= load_cmd;
            waddr_q <= load_cmd.sram_addr;
        end else if (wr_q) begin
            waddr_q <= waddr_q + 1'b1;
        end
        if (beat && !beat_cnt[0]) begin
            low_q <= rdata;
        end
        // low beat sits in the lower half
        if (high_beat) begin
            wdata_q <= {rdata, low_q};
        end
    end

    assign done = last_wr_q;

    assign iram_wr.wen   = wr_q & ~cmd_q.target;
    assign iram_wr.waddr = waddr_q;
    assign iram_wr.wdata = wdata_q;

    assign wram_wr.wen   = wr_q & cmd_q.target;
    assign wram_wr.waddr = waddr_q;
    assign wram_wr.wdata = wdata_q;

    // slave framing must match the issued burst
    assert property (@(posedge clk) disable iff (!rst_n)
        beat |-> (rlast == (beat_cnt == arlen)));

    assert property (@(posedge clk) disable iff (!rst_n)
        beat |-> (rid == arid));

endmodule

/* design/ram_buffer.sv */
`timescale 1ns/1ps

module ram_buffer import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  feed_cmd_t  cmd,
    sram_if.reader     rd,
    output lane_mask_t mxu_vld,
    output entry_t     mxu_pld,
    output logic       done
);

    sram_addr_t       addr_q;
    logic [ROW_W-1:0] rows_left;
    logic             dir_q;
    logic             active;
    logic             out_q;
    logic             last_q;
    lane_mask_t       mask_q;

    // lanes first..first+span, anything past lane 15 is dropped
    function automatic lane_mask_t lane_mask(lane_idx_t first, lane_idx_t span);
        logic [LANE_AW:0] last;
        lane_mask_t       m;
        last = first + span;
        for (int i = 0; i < LANES; i++) begin
            m[i] = (i >= first) && (i <= last);
        end
        return m;
    endfunction

    ////////////////////////////////////////
    // row read sequencer
    ////////////////////////////////////////
    assign rd.ren   = active;
    assign rd.raddr = addr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            addr_q    <= '0;
            rows_left <= '0;
            dir_q     <= 1'b0;
            out_q     <= 1'b0;
            last_q    <= 1'b0;
        end else begin
            out_q  <= active;
            last_q <= active && (rows_left == '0);
            if (start) begin
                active    <= 1'b1;
                addr_q    <= cmd.start_entry;
                rows_left <= cmd.row_len;
                dir_q     <= cmd.row_dir;
            end else if (active) begin
                // wraps around the 256 entries either way
                addr_q    <= dir_q ? addr_q + 1'b1 : addr_q - 1'b1;
                rows_left <= rows_left - 1'b1;
                if (rows_left == '0) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mask_q <= lane_mask(cmd.start_lane, cmd.col_len);
        end
    end

    ////////////////////////////////////////
    // output stage, aligned with rdata
    ////////////////////////////////////////
    assign mxu_vld = out_q ? mask_q : '0;
    assign mxu_pld = rd.rdata;
    assign done    = last_q;

endmodule

/* design/lsu.sv */
`timescale 1ns/1ps

module lsu import lsu_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,

    // from idu
    input  logic             idu_lsu_vld,
    input  logic             idu_lsu_ld_iram,
    input  logic             idu_lsu_ld_wram,
    input  logic             idu_lsu_conv,
    input  dram_addr_t       idu_lsu_dram_addr,
    input  logic [LEN_W-1:0] idu_lsu_len,
    input  sram_baddr_t      idu_lsu_ld_st_addr,
    input  sram_baddr_t      idu_lsu_iram_start_addr,
    input  lane_idx_t        idu_lsu_iram_col_len,
    input  logic [ROW_W-1:0] idu_lsu_iram_row_len,
    input  logic             idu_lsu_iram_row_dir,
    input  sram_baddr_t      idu_lsu_wram_start_addr,
    input  lane_idx_t        idu_lsu_wram_col_len,
    input  logic [ROW_W-1:0] idu_lsu_wram_row_len,
    input  logic             idu_lsu_wram_row_dir,

    // from axi read
    input  logic             axi_lsu_arrdy,
    input  axi_id_t          axi_lsu_rid,
    input  beat_t            axi_lsu_rdata,
    input  logic             axi_lsu_rlast,
    input  logic             axi_lsu_rvld,

    // to idu and mxu
    output logic             lsu_idu_rdy,
    output logic             lsu_mxu_clr,
    output lane_mask_t       lsu_mxu_iram_vld,
    output entry_t           lsu_mxu_iram_pld,
    output lane_mask_t       lsu_mxu_wram_vld,
    output entry_t           lsu_mxu_wram_pld,

    // to axi read
    output axi_id_t          lsu_axi_arid,
    output dram_addr_t       lsu_axi_araddr,
    output axi_len_t         lsu_axi_arlen,
    output logic             lsu_axi_arvld,
    output logic             lsu_axi_rrdy
);

    logic      load_start;
    load_cmd_t load_cmd;
    logic      load_done;
    logic      feed_start;
    feed_cmd_t iram_feed;
    feed_cmd_t wram_feed;
    logic      iram_feed_done;
    logic      wram_feed_done;

    sram_if iram_if ();
    sram_if wram_if ();

    lsu_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .vld             (idu_lsu_vld),
        .ld_iram         (idu_lsu_ld_iram),
        .ld_wram         (idu_lsu_ld_wram),
        .conv            (idu_lsu_conv),
        .dram_addr       (idu_lsu_dram_addr),
        .len             (idu_lsu_len),
        .ld_st_addr      (idu_lsu_ld_st_addr),
        .iram_start_addr (idu_lsu_iram_start_addr),
        .iram_col_len    (idu_lsu_iram_col_len),
        .iram_row_len    (idu_lsu_iram_row_len),
        .iram_row_dir    (idu_lsu_iram_row_dir),
        .wram_start_addr (idu_lsu_wram_start_addr),
        .wram_col_len    (idu_lsu_wram_col_len),
        .wram_row_len    (idu_lsu_wram_row_len),
        .wram_row_dir    (idu_lsu_wram_row_dir),
        .load_done       (load_done),
        .iram_feed_done  (iram_feed_done),
        .wram_feed_done  (wram_feed_done),
        .rdy             (lsu_idu_rdy),
        .clr             (lsu_mxu_clr),
        .load_start      (load_start),
        .load_cmd        (load_cmd),
        .feed_start      (feed_start),
        .iram_feed       (iram_feed),
        .wram_feed       (wram_feed)
    );

    load_buffer u_load (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_start (load_start),
        .load_cmd   (load_cmd),
        .arrdy      (axi_lsu_arrdy),
        .rid        (axi_lsu_rid),
        .rdata      (axi_lsu_rdata),
        .rlast      (axi_lsu_rlast),
        .rvld       (axi_lsu_rvld),
        .arid       (lsu_axi_arid),
        .araddr     (lsu_axi_araddr),
        .arlen      (lsu_axi_arlen),
        .arvld      (lsu_axi_arvld),
        .rrdy       (lsu_axi_rrdy),
        .done       (load_done),
        .iram_wr    (iram_if),
        .wram_wr    (wram_if)
    );

    sram_bank u_iram (.clk(clk), .mem(iram_if));
    sram_bank u_wram (.clk(clk), .mem(wram_if));

    ram_buffer u_iram_feed (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (feed_start),
        .cmd     (iram_feed),
        .rd      (iram_if),
        .mxu_vld (lsu_mxu_iram_vld),
        .mxu_pld (lsu_mxu_iram_pld),
        .done    (iram_feed_done)
    );

    ram_buffer u_wram_feed (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (feed_start),
        .cmd     (wram_feed),
        .rd      (wram_if),
        .mxu_vld (lsu_mxu_wram_vld),
        .mxu_pld (lsu_mxu_wram_pld),
        .done    (wram_feed_done)
    );

endmodule

/* verification/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

    localparam int N_TESTS    = 9;
    localparam int WAIT_LIMIT = 2000;

    // one instruction plus what it should produce
    typedef struct packed {
        logic [1:0]       kind;      // 0 none, 1 iram load, 2 wram load, 3 conv
        dram_addr_t       dram_addr;
        logic [LEN_W-1:0] len;
        sram_addr_t       ld_entry;
        feed_cmd_t        ifeed;
        feed_cmd_t        wfeed;
        axi_len_t         exp_arlen;
        axi_id_t          exp_arid;
        lane_mask_t       exp_imask;
        lane_mask_t       exp_wmask;
    } test_t;

    logic             clk;
    logic             rst_n;
    logic             idu_lsu_vld;
    logic             idu_lsu_ld_iram;
    logic             idu_lsu_ld_wram;
    logic             idu_lsu_conv;
    dram_addr_t       idu_lsu_dram_addr;
    logic [LEN_W-1:0] idu_lsu_len;
    sram_baddr_t      idu_lsu_ld_st_addr;
    sram_baddr_t      idu_lsu_iram_start_addr;
    lane_idx_t        idu_lsu_iram_col_len;
    logic [ROW_W-1:0] idu_lsu_iram_row_len;
    logic             idu_lsu_iram_row_dir;
    sram_baddr_t      idu_lsu_wram_start_addr;
    lane_idx_t        idu_lsu_wram_col_len;
    logic [ROW_W-1:0] idu_lsu_wram_row_len;
    logic             idu_lsu_wram_row_dir;
    logic             axi_lsu_arrdy;
    axi_id_t          axi_lsu_rid;
    beat_t            axi_lsu_rdata;
    logic             axi_lsu_rlast;
    logic             axi_lsu_rvld;
    logic             lsu_idu_rdy;
    logic             lsu_mxu_clr;
    lane_mask_t       lsu_mxu_iram_vld;
    entry_t           lsu_mxu_iram_pld;
    lane_mask_t       lsu_mxu_wram_vld;
    entry_t           lsu_mxu_wram_pld;
    axi_id_t          lsu_axi_arid;
    dram_addr_t       lsu_axi_araddr;
    axi_len_t         lsu_axi_arlen;
    logic             lsu_axi_arvld;
    logic             lsu_axi_rrdy;

    test_t   tbl [N_TESTS];
    string   names [N_TESTS];
    entry_t  iram_model [SRAM_DEPTH];
    entry_t  wram_model [SRAM_DEPTH];
    int      mismatches;
    int      timeouts;
    axi_id_t last_arid;

    // what the slave saw on the address phase
    int         ar_seen;
    int         beats_seen;
    axi_id_t    ar_id;
    dram_addr_t ar_addr;
    axi_len_t   ar_len;

    lsu u_lsu (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // dram content fixed by byte address and beat index
    function automatic beat_t beat_data(dram_addr_t a, int idx);
        dram_addr_t byte_addr;
        byte_addr = a + dram_addr_t'(idx * 8);
        return {1'b1, byte_addr, 16'h5a00 ^ idx[15:0], a[15:0]};
    endfunction

    function automatic feed_cmd_t feed_setup(sram_addr_t e, lane_idx_t lane, lane_idx_t col,
                                             logic [ROW_W-1:0] rows_m1, logic dir);
        feed_cmd_t f;
        f.start_entry = e;
        f.start_lane  = lane;
        f.col_len     = col;
        f.row_len     = rows_m1;
        f.row_dir     = dir;
        return f;
    endfunction

    function automatic test_t load_row(logic wram, dram_addr_t a, logic [LEN_W-1:0] len,
                                       sram_addr_t e, axi_len_t arlen, axi_id_t id);
        test_t t;
        t = '0;
        t.kind      = wram ? 2'd2 : 2'd1;
        t.dram_addr = a;
        t.len       = len;
        t.ld_entry  = e;
        t.exp_arlen = arlen;
        t.exp_arid  = id;
        return t;
    endfunction

    function automatic test_t conv_row(feed_cmd_t i, feed_cmd_t w, lane_mask_t im,
                                       lane_mask_t wm);
        test_t t;
        t = '0;
        t.kind      = 2'd3;
        t.ifeed     = i;
        t.wfeed     = w;
        t.exp_imask = im;
        t.exp_wmask = wm;
        return t;
    endfunction

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout: %s", what);
    endtask

    task automatic wait_ready(input string name);
        int cyc;
        cyc = 0;
        while (!lsu_idu_rdy && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!lsu_idu_rdy) begin
            note_timeout({name, ": LSU never became ready for the instruction"});
        end
    endtask

    // returns 1 ns after the edge that accepts the instruction
    task automatic send_instr(input test_t t, input string name);
        wait_ready(name);
        idu_lsu_vld             = 1'b1;
        idu_lsu_ld_iram         = (t.kind == 2'd1);
        idu_lsu_ld_wram         = (t.kind == 2'd2);
        idu_lsu_conv            = (t.kind == 2'd3);
        idu_lsu_dram_addr       = t.dram_addr;
        idu_lsu_len             = t.len;
        idu_lsu_ld_st_addr      = {t.ld_entry, 4'h0};
        idu_lsu_iram_start_addr = {t.ifeed.start_entry, t.ifeed.start_lane};
        idu_lsu_iram_col_len    = t.ifeed.col_len;
        idu_lsu_iram_row_len    = t.ifeed.row_len;
        idu_lsu_iram_row_dir    = t.ifeed.row_dir;
        idu_lsu_wram_start_addr = {t.wfeed.start_entry, t.wfeed.start_lane};
        idu_lsu_wram_col_len    = t.wfeed.col_len;
        idu_lsu_wram_row_len    = t.wfeed.row_len;
        idu_lsu_wram_row_dir    = t.wfeed.row_dir;
        @(posedge clk);
        #1;
        idu_lsu_vld     = 1'b0;
        idu_lsu_ld_iram = 1'b0;
        idu_lsu_ld_wram = 1'b0;
        idu_lsu_conv    = 1'b0;
    endtask

    ////////////////////////////////////////
    // per instruction checks
    ////////////////////////////////////////

    task automatic load_test(input test_t t, input string name);
        int         cyc;
        sram_addr_t e;
        entry_t     ent;
        ar_seen    = 0;
        beats_seen = 0;
        send_instr(t, name);
        check({name, " arvld after accept"}, 1, lsu_axi_arvld);
        check({name, " rdy while loading"}, 0, lsu_idu_rdy);
        cyc = 0;
        while (!lsu_idu_rdy && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!lsu_idu_rdy) begin
            note_timeout({name, ": rdy did not return after the load"});
        end else begin
            check({name, " address phases"}, 1, ar_seen);
            check({name, " araddr"}, t.dram_addr, ar_addr);
            check({name, " arlen"}, t.exp_arlen, ar_len);
            check({name, " arid"}, t.exp_arid, ar_id);
            check({name, " arid step"}, axi_id_t'(last_arid + 1'b1), ar_id);
            check({name, " beats"}, t.exp_arlen + 1, beats_seen);
            last_arid = ar_id;
            // two beats per entry with the low beat in the lower half
            for (int k = 0; k <= int'(t.len); k++) begin
                e   = sram_addr_t'(t.ld_entry + k);
                ent = {beat_data(t.dram_addr, 2 * k + 1), beat_data(t.dram_addr, 2 * k)};
                if (t.kind == 2'd2) begin
                    wram_model[e] = ent;
                end else begin
                    iram_model[e] = ent;
                end
            end
        end
    endtask

    task automatic conv_test(input test_t t, input string name);
        int         cyc;
        int         irows;
        int         wrows;
        int         clrs;
        int         ifirst;
        int         wfirst;
        sram_addr_t ia;
        sram_addr_t wa;
        cyc    = 0;
        irows  = 0;
        wrows  = 0;
        clrs   = 0;
        ifirst = -1;
        wfirst = -1;
        send_instr(t, name);
        check({name, " clr after accept"}, 1, lsu_mxu_clr);
        while (cyc < WAIT_LIMIT) begin
            if (lsu_mxu_clr) begin
                clrs++;
            end
            if (lsu_mxu_iram_vld != '0) begin
                if (ifirst < 0) begin
                    ifirst = cyc;
                end
                ia = t.ifeed.row_dir ? sram_addr_t'(t.ifeed.start_entry + irows)
                                     : sram_addr_t'(t.ifeed.start_entry - irows);
                check({name, " iram mask"}, t.exp_imask, lsu_mxu_iram_vld);
                check({name, " iram payload"}, iram_model[ia], lsu_mxu_iram_pld);
                irows++;
            end
            if (lsu_mxu_wram_vld != '0) begin
                if (wfirst < 0) begin
                    wfirst = cyc;
                end
                wa = t.wfeed.row_dir ? sram_addr_t'(t.wfeed.start_entry + wrows)
                                     : sram_addr_t'(t.wfeed.start_entry - wrows);
                check({name, " wram mask"}, t.exp_wmask, lsu_mxu_wram_vld);
                check({name, " wram payload"}, wram_model[wa], lsu_mxu_wram_pld);
                wrows++;
            end
            if (lsu_idu_rdy) begin
                break;
            end
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!lsu_idu_rdy) begin
            note_timeout({name, ": rdy did not return after the conv"});
        end
        check({name, " clr cycles"}, 1, clrs);
        check({name, " iram rows"}, t.ifeed.row_len + 1, irows);
        check({name, " wram rows"}, t.wfeed.row_len + 1, wrows);
        check({name, " iram first row cycle"}, 1, ifirst);
        check({name, " wram first row cycle"}, 1, wfirst);
    endtask

    task automatic nop_test(input test_t t, input string name);
        send_instr(t, name);
        check({name, " rdy"}, 1, lsu_idu_rdy);
        check({name, " clr"}, 0, lsu_mxu_clr);
        check({name, " arvld"}, 0, lsu_axi_arvld);
    endtask

    ////////////////////////////////////////
    // axi read slave
    ////////////////////////////////////////
    initial begin : read_slave
        axi_id_t    b_id;
        dram_addr_t b_addr;
        axi_len_t   b_len;
        int         idx;
        logic       in_burst;
        void'($urandom(67679));
        axi_lsu_arrdy = 1'b0;
        axi_lsu_rid   = '0;
        axi_lsu_rdata = '0;
        axi_lsu_rlast = 1'b0;
        axi_lsu_rvld  = 1'b0;
        in_burst      = 1'b0;
        idx           = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!in_burst) begin
                axi_lsu_rvld  = 1'b0;
                axi_lsu_rlast = 1'b0;
                axi_lsu_arrdy = ($urandom_range(3, 0) != 0);
                // handshake lands on the coming edge
                if (lsu_axi_arvld && axi_lsu_arrdy) begin
                    b_id     = lsu_axi_arid;
                    b_addr   = lsu_axi_araddr;
                    b_len    = lsu_axi_arlen;
                    ar_id    = b_id;
                    ar_addr  = b_addr;
                    ar_len   = b_len;
                    ar_seen++;
                    idx      = 0;
                    in_burst = 1'b1;
                end
            end else begin
                axi_lsu_arrdy = 1'b0;
                axi_lsu_rvld  = ($urandom_range(3, 0) != 0);
                axi_lsu_rid   = b_id;
                axi_lsu_rdata = beat_data(b_addr, idx);
                axi_lsu_rlast = (idx == int'(b_len));
                if (axi_lsu_rvld && lsu_axi_rrdy) begin
                    beats_seen++;
                    if (axi_lsu_rlast) begin
                        in_burst = 1'b0;
                    end else begin
                        idx++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        mismatches = 0;
        timeouts   = 0;
        last_arid  = '0;
        ar_seen    = 0;
        beats_seen = 0;
        rst_n      = 1'b0;
        idu_lsu_vld             = 1'b0;
        idu_lsu_ld_iram         = 1'b0;
        idu_lsu_ld_wram         = 1'b0;
        idu_lsu_conv            = 1'b0;
        idu_lsu_dram_addr       = '0;
        idu_lsu_len             = '0;
        idu_lsu_ld_st_addr      = '0;
        idu_lsu_iram_start_addr = '0;
        idu_lsu_iram_col_len    = '0;
        idu_lsu_iram_row_len    = '0;
        idu_lsu_iram_row_dir    = 1'b0;
        idu_lsu_wram_start_addr = '0;
        idu_lsu_wram_col_len    = '0;
        idu_lsu_wram_row_len    = '0;
        idu_lsu_wram_row_dir    = 1'b0;

        tbl[0] = load_row(1'b0, 31'h0000_1000, 8'd3, 8'h10, 8'd7, 8'd1);
        tbl[1] = load_row(1'b1, 31'h0123_4560, 8'd3, 8'h20, 8'd7, 8'd2);
        tbl[2] = conv_row(feed_setup(8'h10, 4'd2, 4'd5, 4'd3, 1'b1),
                          feed_setup(8'h20, 4'd12, 4'd7, 4'd1, 1'b1), 16'h00fc, 16'hf000);
        tbl[3] = conv_row(feed_setup(8'h13, 4'd0, 4'd15, 4'd3, 1'b0),
                          feed_setup(8'h23, 4'd15, 4'd0, 4'd2, 1'b0), 16'hffff, 16'h8000);
        tbl[4] = '0;
        tbl[5] = load_row(1'b0, 31'h7abc_0008, 8'd1, 8'hff, 8'd3, 8'd3);
        // iram rows wrap from entry 255 to 0
        tbl[6] = conv_row(feed_setup(8'hff, 4'd8, 4'd3, 4'd1, 1'b1),
                          feed_setup(8'h21, 4'd0, 4'd0, 4'd0, 1'b1), 16'h0f00, 16'h0001);
        tbl[7] = load_row(1'b1, 31'h0000_0200, 8'd0, 8'h40, 8'd1, 8'd4);
        tbl[8] = conv_row(feed_setup(8'h11, 4'd14, 4'd3, 4'd1, 1'b0),
                          feed_setup(8'h40, 4'd5, 4'd1, 4'd0, 1'b1), 16'hc000, 16'h0060);
        names = '{"load_iram", "load_wram", "conv_ascending", "conv_descending", "no_op",
                  "load_iram_wrap", "conv_wrap", "load_wram_single", "conv_mixed"};

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check("reset rdy", 1, lsu_idu_rdy);
        check("reset clr", 0, lsu_mxu_clr);
        check("reset arvld", 0, lsu_axi_arvld);
        check("reset rrdy", 0, lsu_axi_rrdy);
        check("reset iram mask", 0, lsu_mxu_iram_vld);
        check("reset wram mask", 0, lsu_mxu_wram_vld);

        for (int i = 0; i < N_TESTS; i++) begin
            case (tbl[i].kind)
                2'd1, 2'd2: load_test(tbl[i], names[i]);
                2'd3:       conv_test(tbl[i], names[i]);
                default:    nop_test(tbl[i], names[i]);
            endcase
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
design/lsu_pkg.sv
design/sram_if.sv
design/sram_bank.sv
design/lsu_ctrl.sv
design/load_buffer.sv
design/ram_buffer.sv
design/lsu.sv
verification/lsu_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run, pass only when the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module lsu_tb -o lsu_sim &&
./obj_dir/lsu_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
